//--- Bender.yml
package:
  name: ahb_sram

sources:
  - src/ahb_sram_pkg.sv
  - src/ahb_addr_capture.sv
  - src/sram_access_unit.sv
  - src/ahb_resp_gen.sv
  - src/ahb_sram_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_ahb_sram.sv

//--- src.f
src/ahb_sram_pkg.sv
src/ahb_addr_capture.sv
src/sram_access_unit.sv
src/ahb_resp_gen.sv
src/ahb_sram_top.sv
test/tb_clk_gen.sv
test/tb_ahb_sram.sv

//--- src/ahb_addr_capture.sv
/*
 * AHB-Lite address phase capture
 * Detects accepted transfers, classifies range, size and alignment
 * faults once, and holds the request for the whole data phase
 */

`timescale 1ns/1ps
`default_nettype none

module ahb_addr_capture #(
  parameter  int DEPTH = 256,
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  wire                                clk_ahb,
  input  wire                                sysrst_n,
  input  wire                                hsel_i,
  input  wire                                hready_i,
  input  wire [ahb_sram_pkg::HTRANS_W-1:0]   htrans_i,
  input  wire [ahb_sram_pkg::HADDR_W-1:0]    haddr_i,
  input  wire                                hwrite_i,
  input  wire [ahb_sram_pkg::HSIZE_W-1:0]    hsize_i,
  input  wire                                resp_ready_i,
  output logic                               req_valid_o,
  output logic                               req_write_o,
  output logic [IDX_W-1:0]                   req_index_o,
  output logic [1:0]                         req_offset_o,
  output logic [ahb_sram_pkg::HSIZE_W-1:0]   req_size_o,
  output logic                               req_err_o
);
  import ahb_sram_pkg::*;

  logic accept;
  logic range_err;
  logic size_err;
  logic align_err;

  ////////////////////////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////////////////////////

  // NONSEQ or SEQ, SEQ gets no burst treatment
  assign accept = hsel_i && hready_i && htrans_i[1];

  // Word address past the array end
  assign range_err = {2'b00, haddr_i[HADDR_W-1:2]} >= HADDR_W'(DEPTH);

  // Doubleword and wider are not supported
  assign size_err = hsize_i > HSIZE_WORD;

  // Halfword on odd byte, word off a word boundary
  assign align_err = ((hsize_i == HSIZE_HALF) && haddr_i[0]) ||
                     ((hsize_i == HSIZE_WORD) && (haddr_i[1:0] != 2'b00));

  ////////////////////////////////////////////////////////////
  // Request registers
  ////////////////////////////////////////////////////////////

  // Held until the edge that ends the data phase
  always_ff @(posedge clk_ahb or negedge sysrst_n) begin
    if (!sysrst_n) begin
      req_valid_o <= 1'b0;
    end else if (accept) begin
      req_valid_o <= 1'b1;
    end else if (resp_ready_i) begin
      req_valid_o <= 1'b0;
    end
  end

  // Request payload, only meaningful while req_valid_o
  always_ff @(posedge clk_ahb) begin
    if (accept) begin
      req_write_o  <= hwrite_i;
      req_index_o  <= haddr_i[IDX_W+1:2];
      req_offset_o <= haddr_i[1:0];
      req_size_o   <= hsize_i;
      req_err_o    <= range_err || size_err || align_err;
    end
  end

  // Master must drive a clean address phase when selected
  a_addr_known: assert property (@(posedge clk_ahb) disable iff (!sysrst_n)
    accept |-> !$isunknown({hsize_i, haddr_i}));

endmodule

`default_nettype wire

//--- src/ahb_resp_gen.sv
/*
 * AHB-Lite response generator
 * Drives HREADYOUT, HRESP and HRDATA, with the two cycle ERROR
 */

`timescale 1ns/1ps
`default_nettype none

module ahb_resp_gen (
  input  wire                         clk_ahb,
  input  wire                         sysrst_n,
  input  wire                         acc_done_i,
  input  wire                         acc_err_i,
  input  wire ahb_sram_pkg::hdata_u   acc_rdata_i,
  output logic                        hreadyout_o,
  output logic                        hresp_o,
  output ahb_sram_pkg::hdata_u        hrdata_o
);
  import ahb_sram_pkg::*;

  // Response phases
  localparam logic [1:0] ST_WAIT = 2'd0;
  localparam logic [1:0] ST_ERR1 = 2'd1;
  localparam logic [1:0] ST_ERR2 = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state_cur;
  logic       waited_q;
  hdata_u     rdata_q;

  ////////////////////////////////////////////////////////////
  // Response FSM
  ////////////////////////////////////////////////////////////

  // state_q is the phase of the previous cycle
  always_comb begin
    if (state_q == ST_ERR1) begin
      state_cur = ST_ERR2;
    end else if (acc_done_i && acc_err_i) begin
      state_cur = ST_ERR1;
    end else begin
      state_cur = ST_WAIT;
    end
  end

  always_comb begin
    case (state_cur)
      ST_ERR1: begin
        hreadyout_o = 1'b0;
        hresp_o     = 1'b1;
      end
      ST_ERR2: begin
        hreadyout_o = 1'b1;
        hresp_o     = 1'b1;
      end
      default: begin
        hreadyout_o = acc_done_i;
        hresp_o     = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_ahb or negedge sysrst_n) begin
    if (!sysrst_n) begin
      state_q  <= ST_WAIT;
      waited_q <= 1'b0;
    end else begin
      state_q  <= state_cur;
      waited_q <= (state_cur == ST_WAIT) && !acc_done_i;
    end
  end

  // Read word sampled during wait cycles
  always_ff @(posedge clk_ahb) begin
    if ((state_cur == ST_WAIT) && !acc_done_i) begin
      rdata_q <= acc_rdata_i;
    end
  end

  // Zero wait reads take the word straight from the array
  assign hrdata_o = waited_q ? rdata_q : acc_rdata_i;

  // OKAY-ready with HRESP high only as second ERROR cycle
  a_err_two_cycle: assert property (@(posedge clk_ahb) disable iff (!sysrst_n)
    (hresp_o && hreadyout_o) |-> $past(hresp_o && !hreadyout_o));

endmodule

`default_nettype wire

//--- src/ahb_sram_pkg.sv
/*
 * AHB-Lite SRAM slave shared definitions
 * Bus widths, HTRANS and HSIZE codes, and the data word union
 * that views one bus word either whole or as byte lanes
 */

`default_nettype none

package ahb_sram_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int HADDR_W  = 32;
  localparam int HDATA_W  = 32;
  localparam int HSIZE_W  = 3;
  localparam int HTRANS_W = 2;

  // Byte lanes in one data word
  localparam int HLANES = HDATA_W / 8;

  // Transfer types, only bit 1 matters to this slave
  localparam logic [HTRANS_W-1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [HTRANS_W-1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [HTRANS_W-1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [HTRANS_W-1:0] HTRANS_SEQ    = 2'b11;

  // Transfer sizes up to one word
  localparam logic [HSIZE_W-1:0] HSIZE_BYTE = 3'b000;
  localparam logic [HSIZE_W-1:0] HSIZE_HALF = 3'b001;
  localparam logic [HSIZE_W-1:0] HSIZE_WORD = 3'b010;

  // Whole word, or lane 0 = byte at offset 0 (little endian)
  typedef union packed {
    logic [HDATA_W-1:0]     word;
    logic [HLANES-1:0][7:0] lanes;
  } hdata_u;

endpackage

`default_nettype wire

//--- src/ahb_sram_top.sv
/*
 * AHB-Lite on-chip SRAM emulation slave
 * Single port, LATENCY wait states per data phase, DEPTH words
 */

`timescale 1ns/1ps
`default_nettype none

module ahb_sram_top #(
  parameter int LATENCY = 3,
  parameter int DEPTH   = 256
) (
  input  wire                                clk_ahb,
  input  wire                                sysrst_n,
  input  wire                                hsel_i,
  input  wire                                hready_i,
  input  wire [ahb_sram_pkg::HTRANS_W-1:0]   htrans_i,
  input  wire [ahb_sram_pkg::HADDR_W-1:0]    haddr_i,
  input  wire                                hwrite_i,
  input  wire [ahb_sram_pkg::HSIZE_W-1:0]    hsize_i,
  input  wire ahb_sram_pkg::hdata_u          hwdata_i,
  output ahb_sram_pkg::hdata_u               hrdata_o,
  output logic                               hreadyout_o,
  output logic                               hresp_o
);
  import ahb_sram_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Captured request
  logic               req_valid;
  logic               req_write;
  logic [IDX_W-1:0]   req_index;
  logic [1:0]         req_offset;
  logic [HSIZE_W-1:0] req_size;
  logic               req_err;

  // Access result
  logic               acc_done;
  logic               acc_err;
  hdata_u             acc_rdata;

  // End of data phase, fed back to both earlier stages
  logic               resp_ready;

  assign resp_ready = hreadyout_o;

  ahb_addr_capture #(
    .DEPTH (DEPTH)
  ) u_addr_capture (
    .clk_ahb      (clk_ahb),
    .sysrst_n     (sysrst_n),
    .hsel_i       (hsel_i),
    .hready_i     (hready_i),
    .htrans_i     (htrans_i),
    .haddr_i      (haddr_i),
    .hwrite_i     (hwrite_i),
    .hsize_i      (hsize_i),
    .resp_ready_i (resp_ready),
    .req_valid_o  (req_valid),
    .req_write_o  (req_write),
    .req_index_o  (req_index),
    .req_offset_o (req_offset),
    .req_size_o   (req_size),
    .req_err_o    (req_err)
  );

  sram_access_unit #(
    .LATENCY (LATENCY),
    .DEPTH   (DEPTH)
  ) u_access (
    .clk_ahb      (clk_ahb),
    .sysrst_n     (sysrst_n),
    .req_valid_i  (req_valid),
    .req_write_i  (req_write),
    .req_index_i  (req_index),
    .req_offset_i (req_offset),
    .req_size_i   (req_size),
    .req_err_i    (req_err),
    .resp_ready_i (resp_ready),
    .hwdata_i     (hwdata_i),
    .acc_done_o   (acc_done),
    .acc_err_o    (acc_err),
    .acc_rdata_o  (acc_rdata)
  );

  ahb_resp_gen u_resp_gen (
    .clk_ahb     (clk_ahb),
    .sysrst_n    (sysrst_n),
    .acc_done_i  (acc_done),
    .acc_err_i   (acc_err),
    .acc_rdata_i (acc_rdata),
    .hreadyout_o (hreadyout_o),
    .hresp_o     (hresp_o),
    .hrdata_o    (hrdata_o)
  );

endmodule

`default_nettype wire

//--- src/sram_access_unit.sv
/*
 * SRAM access unit
 * Wait state counter, word array, byte lane write merge
 * and read word for the response stage
 */

`timescale 1ns/1ps
`default_nettype none

module sram_access_unit #(
  parameter  int LATENCY = 3,
  parameter  int DEPTH   = 256,
  localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  wire                                clk_ahb,
  input  wire                                sysrst_n,
  input  wire                                req_valid_i,
  input  wire                                req_write_i,
  input  wire [IDX_W-1:0]                    req_index_i,
  input  wire [1:0]                          req_offset_i,
  input  wire [ahb_sram_pkg::HSIZE_W-1:0]    req_size_i,
  input  wire                                req_err_i,
  input  wire                                resp_ready_i,
  input  wire ahb_sram_pkg::hdata_u          hwdata_i,
  output logic                               acc_done_o,
  output logic                               acc_err_o,
  output ahb_sram_pkg::hdata_u               acc_rdata_o
);
  import ahb_sram_pkg::*;

  // Counter sized for the 0 to 15 wait state range
  localparam logic [3:0] WAIT_LAST = 4'(LATENCY);

  hdata_u            mem [DEPTH];
  logic [3:0]        wait_cnt;
  logic [HLANES-1:0] lane_en;
  logic              mem_we;
  hdata_u            merged;

  ////////////////////////////////////////////////////////////
  // Wait state timing
  ////////////////////////////////////////////////////////////

  // Cleared by every cycle with HREADYOUT high
  // so each data phase starts counting at zero
  always_ff @(posedge clk_ahb or negedge sysrst_n) begin
    if (!sysrst_n) begin
      wait_cnt <= '0;
    end else if (resp_ready_i) begin
      wait_cnt <= '0;
    end else if (req_valid_i && (wait_cnt != WAIT_LAST)) begin
      wait_cnt <= wait_cnt + 4'd1;
    end
  end

  // Data phase may end once all waits are used up
  // No pending request behaves as a zero wait OKAY
  assign acc_done_o = !req_valid_i || (wait_cnt == WAIT_LAST);
  assign acc_err_o  = req_valid_i && req_err_i;

  ////////////////////////////////////////////////////////////
  // Byte lane merge and array
  ////////////////////////////////////////////////////////////

  // Lanes touched by the transfer
  always_comb begin
    lane_en = '0;
    case (req_size_i)
      HSIZE_BYTE: lane_en[req_offset_i] = 1'b1;
      HSIZE_HALF: lane_en[{req_offset_i[1], 1'b0} +: 2] = 2'b11;
      HSIZE_WORD: lane_en = '1;
      default:    lane_en = '0;
    endcase
  end

  // Old word with the written lanes replaced
  always_comb begin
    merged = mem[req_index_i];
    for (int i = 0; i < HLANES; i++) begin
      if (lane_en[i]) begin
        merged.lanes[i] = hwdata_i.lanes[i];
      end
    end
  end

  // Commit on the edge closing a clean write
  // HWDATA is valid in that final cycle
  assign mem_we = req_valid_i && req_write_i && !req_err_i && resp_ready_i;

  always_ff @(posedge clk_ahb) begin
    if (mem_we) begin
      mem[req_index_i] <= merged;
    end
  end

  // Zero outside reads keeps HRDATA quiet when idle
  assign acc_rdata_o = (req_valid_i && !req_write_i) ? mem[req_index_i] : '0;

  // A committed write never carries a range, size or alignment fault
  a_write_legal: assert property (@(posedge clk_ahb) disable iff (!sysrst_n)
    mem_we |-> acc_done_o && (req_index_i < DEPTH) && (req_size_i <= HSIZE_WORD) &&
               !((req_size_i == HSIZE_HALF) && req_offset_i[0]) &&
               !((req_size_i == HSIZE_WORD) && (req_offset_i != 2'b00)));

endmodule

`default_nettype wire

//--- test/tb_ahb_sram.sv
/*
 * Testbench for the AHB-Lite SRAM slave
 * Pipelined master on the falling edge, bus checker on the rising edge,
 * reference model of the word array with byte lane merging
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ahb_sram;
  import ahb_sram_pkg::*;

  localparam int LATENCY       = 3;
  localparam int DEPTH         = 256;
  localparam int READY_TIMEOUT = 64;
  localparam int PHASE_TIMEOUT = 32;
  localparam int WINDOW        = 16;

  logic                clk_ahb;
  logic                sysrst_n;
  logic                hsel;
  logic [HTRANS_W-1:0] htrans;
  logic [HADDR_W-1:0]  haddr;
  logic                hwrite;
  logic [HSIZE_W-1:0]  hsize;
  hdata_u              hwdata;
  hdata_u              hrdata;
  logic                hreadyout;
  logic                hresp;

  // Reference word array
  hdata_u              model [DEPTH];
  string               cur_test = "startup";
  int                  issued   = 0;
  int                  checked  = 0;

  // Data phase seen by the checker
  logic                busy = 1'b0;
  logic                ph_write;
  logic [HADDR_W-1:0]  ph_addr;
  logic [HSIZE_W-1:0]  ph_size;
  int                  low_ok;
  int                  low_err;

  tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clk_gen (
    .clk_ahb_o  (clk_ahb),
    .sysrst_n_o (sysrst_n)
  );

  // Single slave, so HREADY loops back from HREADYOUT
  ahb_sram_top #(.LATENCY(LATENCY), .DEPTH(DEPTH)) u_dut (
    .clk_ahb     (clk_ahb),
    .sysrst_n    (sysrst_n),
    .hsel_i      (hsel),
    .hready_i    (hreadyout),
    .htrans_i    (htrans),
    .haddr_i     (haddr),
    .hwrite_i    (hwrite),
    .hsize_i     (hsize),
    .hwdata_i    (hwdata),
    .hrdata_o    (hrdata),
    .hreadyout_o (hreadyout),
    .hresp_o     (hresp)
  );

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic compare_data(input string what, input hdata_u exp, input hdata_u act);
    if (act !== exp) begin
      $display("ERROR %s %s expected %h actual %h", cur_test, what, exp.word, act.word);
      abort_run();
    end
  endtask

  task automatic compare_resp(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s %s expected %b actual %b", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_wait(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("ERROR %s %s expected %0d actual %0d", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  // Expected outcome of one transfer, model updated for clean writes
  function automatic logic predict_access(input logic wr, input logic [HADDR_W-1:0] addr,
                                          input logic [HSIZE_W-1:0] size, input hdata_u wdata,
                                          output hdata_u rdata);
    int unsigned idx;
    int unsigned nbytes;
    logic        err;
    idx    = addr >> 2;
    nbytes = 1 << size;
    err    = (idx >= DEPTH) || (size > HSIZE_WORD) || ((addr % nbytes) != 0);
    rdata  = '0;
    if (!err) begin
      rdata = model[idx];
      if (wr) begin
        for (int b = 0; b < nbytes; b++) begin
          model[idx].lanes[addr[1:0] + b] = wdata.lanes[addr[1:0] + b];
        end
      end
    end
    return err;
  endfunction

  ////////////////////////////////////////////////////////////
  // Master side
  ////////////////////////////////////////////////////////////

  task automatic await_ready(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_ahb);
      cycles++;
      if (cycles > READY_TIMEOUT) begin
        $display("Timeout in %s: HREADYOUT stayed low during %s", cur_test, what);
        abort_run();
      end
    end while (!hreadyout);
  endtask

  // Address phase now, write data from the next falling edge on
  task automatic issue_transfer(input logic wr, input logic [HADDR_W-1:0] addr,
                                input logic [HSIZE_W-1:0] size, input hdata_u wdata);
    htrans = HTRANS_NONSEQ;
    haddr  = addr;
    hwrite = wr;
    hsize  = size;
    await_ready("address phase");
    issued++;
    @(negedge clk_ahb);
    hwdata = wdata;
    htrans = HTRANS_IDLE;
  endtask

  task automatic insert_idle(input int n);
    htrans = HTRANS_IDLE;
    repeat (n) await_ready("idle cycle");
    @(negedge clk_ahb);
  endtask

  task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    while (busy) begin
      @(negedge clk_ahb);
      cycles++;
      if (cycles > READY_TIMEOUT) begin
        $display("Timeout in %s: last data phase never completed", cur_test);
        abort_run();
      end
    end
  endtask

  task automatic hold_until_reset_done();
    int cycles;
    cycles = 0;
    while (!sysrst_n) begin
      @(negedge clk_ahb);
      cycles++;
      if (cycles > 20) begin
        $display("Timeout: reset was never released");
        abort_run();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus checker
  ////////////////////////////////////////////////////////////

  always @(posedge clk_ahb) begin : check_bus
    hdata_u exp_rdata;
    logic   exp_err;
    if (sysrst_n) begin
      if (busy && !hreadyout) begin
        if (hresp) low_err++;
        else low_ok++;
        if (low_ok + low_err > PHASE_TIMEOUT) begin
          $display("Timeout in %s: data phase at %h never completed", cur_test, ph_addr);
          abort_run();
        end
      end else if (busy) begin
        // HWDATA of the final cycle is the committed data
        exp_err = predict_access(ph_write, ph_addr, ph_size, hwdata, exp_rdata);
        compare_wait("wait cycles", LATENCY, low_ok);
        compare_wait("error low cycles", exp_err ? 1 : 0, low_err);
        compare_resp("hresp", exp_err, hresp);
        if (!exp_err && !ph_write) compare_data("read data", exp_rdata, hrdata);
        checked++;
        busy = 1'b0;
      end
      // Next address phase may overlap the completing cycle
      if (hsel && hreadyout && htrans[1]) begin
        busy     = 1'b1;
        ph_write = hwrite;
        ph_addr  = haddr;
        ph_size  = hsize;
        low_ok   = 0;
        low_err  = 0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    hdata_u             wdata;
    logic [HADDR_W-1:0] addr;
    logic [HSIZE_W-1:0] size;
    int                 kind;
    void'($urandom(32'he071_7617));
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    haddr  = '0;
    hwrite = 1'b0;
    hsize  = HSIZE_BYTE;
    hwdata = '0;
    hold_until_reset_done();

    cur_test = "reset_state";
    compare_resp("hreadyout", 1'b1, hreadyout);
    compare_resp("hresp", 1'b0, hresp);
    compare_data("hrdata", '0, hrdata);
    hsel = 1'b1;

    cur_test = "word_write_read";
    for (int i = 0; i < 8; i++) begin
      wdata.word = $urandom;
      issue_transfer(1'b1, 32'(i * 4), HSIZE_WORD, wdata);
    end
    for (int i = 0; i < 8; i++) begin
      wdata.word = $urandom;
      issue_transfer(1'b0, 32'(i * 4), HSIZE_WORD, wdata);
    end
    drain_pipeline();

    cur_test = "byte_half_merge";
    wdata.word = $urandom;
    issue_transfer(1'b1, 32'h20, HSIZE_WORD, wdata);
    for (int off = 0; off < 4; off++) begin
      wdata.word = $urandom;
      issue_transfer(1'b1, 32'h20 + off, HSIZE_BYTE, wdata);
      issue_transfer(1'b0, 32'h20, HSIZE_WORD, wdata);
    end
    for (int off = 0; off < 4; off += 2) begin
      wdata.word = $urandom;
      issue_transfer(1'b1, 32'h20 + off, HSIZE_HALF, wdata);
      issue_transfer(1'b0, 32'h20, HSIZE_WORD, wdata);
    end
    drain_pipeline();

    // Out of range, doubleword, odd halfword, then the old contents
    cur_test = "error_response";
    wdata.word = $urandom;
    issue_transfer(1'b1, 32'(DEPTH * 4), HSIZE_WORD, wdata);
    issue_transfer(1'b1, 32'h10, 3'b011, wdata);
    issue_transfer(1'b1, 32'h21, HSIZE_HALF, wdata);
    issue_transfer(1'b0, 32'h00, HSIZE_WORD, wdata);
    issue_transfer(1'b0, 32'h10, HSIZE_WORD, wdata);
    issue_transfer(1'b0, 32'h20, HSIZE_WORD, wdata);
    drain_pipeline();

    cur_test = "random_traffic";
    for (int i = 0; i < WINDOW; i++) begin
      wdata.word = $urandom;
      issue_transfer(1'b1, 32'(i * 4), HSIZE_WORD, wdata);
    end
    for (int n = 0; n < 300; n++) begin
      kind       = $urandom_range(9, 0);
      size       = 3'($urandom_range(2, 0));
      addr       = 32'($urandom_range(WINDOW - 1, 0)) << 2;
      addr       = addr | ((32'($urandom_range(3, 0)) >> size) << size);
      wdata.word = $urandom;
      if (kind == 0) begin
        insert_idle($urandom_range(3, 1));
      end else if (kind == 1) begin
        issue_transfer(1'($urandom_range(1, 0)), addr | 32'h8000_0000, size, wdata);
      end else if (kind < 6) begin
        issue_transfer(1'b0, addr, size, wdata);
      end else begin
        issue_transfer(1'b1, addr, size, wdata);
        // Read back the same word right behind the write
        if ($urandom_range(2, 0) == 0) begin
          issue_transfer(1'b0, {addr[HADDR_W-1:2], 2'b00}, HSIZE_WORD, wdata);
        end
      end
    end
    drain_pipeline();

    if ((checked == issued) && (checked > 0)) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Checker completed %0d transfers but %0d were issued", checked, issued);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 * Free running clk_ahb, sysrst_n held low for a few cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_ahb_o,
  output logic sysrst_n_o
);

  initial begin
    clk_ahb_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_ahb_o = ~clk_ahb_o;
  end

  // Released on a falling edge, half a cycle away from the flops
  initial begin
    sysrst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_ahb_o);
    @(negedge clk_ahb_o);
    sysrst_n_o = 1'b1;
  end

endmodule

`default_nettype wire
